// ==== Makefile ====
# Verilator build and run for the spike rate subsystem

VERILATOR ?= verilator
TOP       ?= spike_rate_tb
FILELIST  ?= spike_rate.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation completed successfully

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# pass only if the pass line shows up in the output
run: compile
	@out="$$(./$(SIM_BIN) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== logic/count_fifo.sv ====
`default_nettype none
`timescale 1ns/1ns

module count_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire                          i_wr,
    input  wire spike_rate_pkg::record_t i_wr_data,
    input  wire                          i_pop,
    output spike_rate_pkg::record_t      o_rd_data,
    output logic                         o_empty,
    output logic                         o_overflow
);

    // address width, pointers carry one extra wrap bit
    localparam int AW = $clog2(FIFO_DEPTH);

    spike_rate_pkg::record_t mem [FIFO_DEPTH];

    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        do_wr;
    logic        do_pop;

    ////////////////////////////////////////////////////////////////////////////
    // status
    ////////////////////////////////////////////////////////////////////////////

    // same address, different lap -> full
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) &&
                     (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign o_empty = (wr_ptr == rd_ptr);

    // writes into a full buffer are lost
    assign do_wr  = i_wr && !full;
    assign do_pop = i_pop && !o_empty;

    // storage
    always_ff @(posedge i_clk)
    begin
        if (do_wr)
            mem[wr_ptr[AW-1:0]] <= i_wr_data;
    end

    // pointers
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // sticky until reset
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            o_overflow <= 1'b0;
        else if (i_wr && full)
            o_overflow <= 1'b1;
    end

    // head of queue, shown without a read cycle
    assign o_rd_data = mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

// ==== logic/pipe_readout.sv ====
`default_nettype none
`timescale 1ns/1ns

module pipe_readout (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire                          i_empty,
    input  wire spike_rate_pkg::record_t i_rd_data,
    input  wire                          i_pipe_read,
    output logic                         o_pop,
    output logic                         o_pipe_valid,
    output spike_rate_pkg::host_word_t   o_pipe_data
);

    localparam int HALF_W = $bits(spike_rate_pkg::host_word_t);

    typedef enum logic {LOW, HIGH} half_state_t;

    half_state_t half;

    // read strobe that actually counts
    logic take;

    ////////////////////////////////////////////////////////////////////////////
    // half select
    ////////////////////////////////////////////////////////////////////////////

    // data present whenever the fifo holds a record
    assign o_pipe_valid = !i_empty;

    // strobes with nothing to show are dropped
    assign take = i_pipe_read && o_pipe_valid;

    // low half first, then high half
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            half <= LOW;
        end
        else if (take)
        begin
            case (half)
                LOW:     half <= HIGH;
                HIGH:    half <= LOW;
                default: half <= LOW;
            endcase
        end
    end

    // record leaves the fifo once its high half is read
    assign o_pop = take && (half == HIGH);

    // word mux
    always_comb
    begin
        if (half == HIGH)
            o_pipe_data = i_rd_data[2*HALF_W-1:HALF_W];
        else
            o_pipe_data = i_rd_data[HALF_W-1:0];
    end

endmodule

`default_nettype wire

// ==== logic/spike_counter.sv ====
`default_nettype none
`timescale 1ns/1ns

module spike_counter #(
    parameter int NUM_CH = 4
) (
    input  wire                        i_clk,
    input  wire                        i_reset,
    input  wire [NUM_CH-1:0]           i_spike,
    input  wire [NUM_CH-1:0]           i_enable,
    input  wire                        i_window_end,
    output logic                       o_rec_valid,
    output spike_rate_pkg::record_t    o_rec_data
);

    // index width into the snapshot
    localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

    typedef enum logic {COUNT, DUMP} dump_state_t;

    // two-flop synchronizer plus one stage for edge detect
    logic [NUM_CH-1:0] spike_meta;
    logic [NUM_CH-1:0] spike_sync;
    logic [NUM_CH-1:0] spike_prev;
    logic [NUM_CH-1:0] spike_rise;

    spike_rate_pkg::count_t counts [NUM_CH];
    spike_rate_pkg::count_t snap   [NUM_CH];

    dump_state_t            state;
    spike_rate_pkg::chan_t  dump_ch;

    ////////////////////////////////////////////////////////////////////////////
    // input sync and edge detect
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            spike_meta <= '0;
            spike_sync <= '0;
            spike_prev <= '0;
        end
        else
        begin
            spike_meta <= i_spike;
            spike_sync <= spike_meta;
            spike_prev <= spike_sync;
        end
    end

    // disabled channels do not count at all
    assign spike_rise = spike_sync & ~spike_prev & i_enable;

    // per-channel counters, saturating
    // at window end an edge in the same cycle starts the new window at 1
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < NUM_CH; i++)
                counts[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < NUM_CH; i++)
            begin
                if (i_window_end)
                    counts[i] <= spike_rate_pkg::count_t'(spike_rise[i]);
                else if (spike_rise[i] && (counts[i] != '1))
                    counts[i] <= counts[i] + 1'b1;
            end
        end
    end

    // snapshot for the dump, masked again for channels turned off mid-window
    always_ff @(posedge i_clk)
    begin
        if (i_window_end)
        begin
            for (int i = 0; i < NUM_CH; i++)
                snap[i] <= i_enable[i] ? counts[i] : '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // dump FSM, one record per cycle
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state   <= COUNT;
            dump_ch <= '0;
        end
        else
        begin
            case (state)
                COUNT:
                begin
                    if (i_window_end)
                    begin
                        state   <= DUMP;
                        dump_ch <= '0;
                    end
                end
                DUMP:
                begin
                    // a window end here would restart the walk
                    if (i_window_end)
                        dump_ch <= '0;
                    else if (dump_ch == spike_rate_pkg::chan_t'(NUM_CH - 1))
                        state <= COUNT;
                    else
                        dump_ch <= dump_ch + 1'b1;
                end
                default:
                begin
                    state <= COUNT;
                end
            endcase
        end
    end

    assign o_rec_valid = (state == DUMP);
    assign o_rec_data  = {dump_ch, snap[dump_ch[CH_W-1:0]]};

endmodule

`default_nettype wire

// ==== logic/spike_rate_pkg.sv ====
`default_nettype none

package spike_rate_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths that carry a meaning
    ////////////////////////////////////////////////////////////////////////////

    // spikes seen on one channel within one window
    typedef logic [23:0] count_t;

    // channel number as stored in a record
    typedef logic [7:0] chan_t;

    // fifo entry
    // channel in [31:24], count in [23:0]
    typedef logic [31:0] record_t;

    // one host wire or one pipe word
    typedef logic [15:0] host_word_t;

    // host parameter, built as {wire_hi, wire_lo}
    typedef logic [31:0] param_t;

    ////////////////////////////////////////////////////////////////////////////
    // trigger map and reset values
    ////////////////////////////////////////////////////////////////////////////

    // bit positions in the trigger word
    localparam int TRIG_WINDOW = 0;
    localparam int TRIG_ENABLE = 1;

    // window lasts len + 1 cycles, so 10 cycles out of reset
    localparam param_t WINDOW_RESET = param_t'(9);

    // all channels on by default
    localparam param_t ENABLE_RESET = '1;

endpackage

`default_nettype wire

// ==== logic/spike_rate_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module spike_rate_top #(
    parameter int NUM_CH     = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  wire                             ep50trig,
    input  wire                             reset_global,
    input  wire [NUM_CH-1:0]                i_spike,
    input  wire spike_rate_pkg::host_word_t i_trig,
    input  wire spike_rate_pkg::host_word_t i_wire_hi,
    input  wire spike_rate_pkg::host_word_t i_wire_lo,
    input  wire                             i_pipe_read,
    output logic                            o_pipe_valid,
    output spike_rate_pkg::host_word_t      o_pipe_data,
    output logic                            o_overflow,
    output logic                            o_window_tick
);

    // host parameters
    spike_rate_pkg::param_t  window_len;
    logic [NUM_CH-1:0]       enable;

    // timer -> counter
    logic                    window_end;

    // counter -> fifo
    logic                    rec_valid;
    spike_rate_pkg::record_t rec_data;

    // fifo <-> readout
    spike_rate_pkg::record_t rd_data;
    logic                    empty;
    logic                    rd_pop;

    ////////////////////////////////////////////////////////////////////////////
    // host-loaded settings and window timing
    ////////////////////////////////////////////////////////////////////////////

    trig_param_bank #(.NUM_CH(NUM_CH)) u_param_bank (
        .i_clk        (ep50trig),
        .i_reset      (reset_global),
        .i_trig       (i_trig),
        .i_wire_hi    (i_wire_hi),
        .i_wire_lo    (i_wire_lo),
        .o_window_len (window_len),
        .o_enable     (enable)
    );

    window_timer u_window_timer (
        .i_clk        (ep50trig),
        .i_reset      (reset_global),
        .i_window_len (window_len),
        .o_window_end (window_end)
    );

    // window strobe brought out as a pin
    assign o_window_tick = window_end;

    ////////////////////////////////////////////////////////////////////////////
    // datapath, counter -> fifo -> host pipe
    ////////////////////////////////////////////////////////////////////////////

    spike_counter #(.NUM_CH(NUM_CH)) u_spike_counter (
        .i_clk        (ep50trig),
        .i_reset      (reset_global),
        .i_spike      (i_spike),
        .i_enable     (enable),
        .i_window_end (window_end),
        .o_rec_valid  (rec_valid),
        .o_rec_data   (rec_data)
    );

    count_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_count_fifo (
        .i_clk      (ep50trig),
        .i_reset    (reset_global),
        .i_wr       (rec_valid),
        .i_wr_data  (rec_data),
        .i_pop      (rd_pop),
        .o_rd_data  (rd_data),
        .o_empty    (empty),
        .o_overflow (o_overflow)
    );

    pipe_readout u_pipe_readout (
        .i_clk        (ep50trig),
        .i_reset      (reset_global),
        .i_empty      (empty),
        .i_rd_data    (rd_data),
        .i_pipe_read  (i_pipe_read),
        .o_pop        (rd_pop),
        .o_pipe_valid (o_pipe_valid),
        .o_pipe_data  (o_pipe_data)
    );

endmodule

`default_nettype wire

// ==== logic/trig_param_bank.sv ====
`default_nettype none
`timescale 1ns/1ns

module trig_param_bank #(
    parameter int NUM_CH = 4
) (
    input  wire                        i_clk,
    input  wire                        i_reset,
    input  wire spike_rate_pkg::host_word_t i_trig,
    input  wire spike_rate_pkg::host_word_t i_wire_hi,
    input  wire spike_rate_pkg::host_word_t i_wire_lo,
    output spike_rate_pkg::param_t     o_window_len,
    output logic [NUM_CH-1:0]          o_enable
);

    // value presented by the host on the two wires
    spike_rate_pkg::param_t load_word;

    // shortest window that still fits a full dump
    localparam spike_rate_pkg::param_t MIN_LEN = spike_rate_pkg::param_t'(NUM_CH);

    assign load_word = {i_wire_hi, i_wire_lo};

    ////////////////////////////////////////////////////////////////////////////
    // trigger-loaded registers
    ////////////////////////////////////////////////////////////////////////////

    // window length
    // a trigger pulse loads on the same edge, visible next cycle
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_window_len <= spike_rate_pkg::WINDOW_RESET;
        end
        else if (i_trig[spike_rate_pkg::TRIG_WINDOW])
        begin
            // clamp so the dump of NUM_CH records ends before next window end
            if (load_word < MIN_LEN)
                o_window_len <= MIN_LEN;
            else
                o_window_len <= load_word;
        end
    end

    // channel enable mask
    // only the low NUM_CH bits of the word matter
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_enable <= spike_rate_pkg::ENABLE_RESET[NUM_CH-1:0];
        end
        else if (i_trig[spike_rate_pkg::TRIG_ENABLE])
        begin
            o_enable <= load_word[NUM_CH-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== logic/window_timer.sv ====
`default_nettype none
`timescale 1ns/1ns

module window_timer (
    input  wire                         i_clk,
    input  wire                         i_reset,
    input  wire spike_rate_pkg::param_t i_window_len,
    output logic                        o_window_end
);

    // cycles left in the current window
    spike_rate_pkg::param_t remain;

    ////////////////////////////////////////////////////////////////////////////
    // down-counter
    ////////////////////////////////////////////////////////////////////////////

    // starts at the reset length, so the first end lands 10 cycles out
    // reload at zero, one window is len + 1 cycles
    // the length is sampled only at reload, so a new value
    // takes effect one window later
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            remain <= spike_rate_pkg::WINDOW_RESET;
        end
        else if (remain == '0)
        begin
            remain <= i_window_len;
        end
        else
        begin
            remain <= remain - 1'b1;
        end
    end

    // last cycle of the window
    // held high for exactly one cycle since reload is never zero
    assign o_window_end = (remain == '0);

endmodule

`default_nettype wire

// ==== spike_rate.f ====
logic/spike_rate_pkg.sv
logic/trig_param_bank.sv
logic/window_timer.sv
logic/spike_counter.sv
logic/count_fifo.sv
logic/pipe_readout.sv
logic/spike_rate_top.sv
test/spike_rate_asserts.sv
test/spike_rate_tb.sv

// ==== test/spike_rate_asserts.sv ====
`default_nettype none
`timescale 1ns/1ns

module spike_rate_asserts #(
    parameter int NUM_CH = 4
) (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire                          i_window_tick,
    input  wire                          i_pipe_valid,
    input  wire                          i_overflow,
    input  wire                          i_rec_valid,
    input  wire spike_rate_pkg::record_t i_rec_data
);

    // failed assertions so far, read by the testbench at the end
    int fail_count = 0;

    ////////////////////////////////////////////////////////////////////////////
    // window strobe and host side
    ////////////////////////////////////////////////////////////////////////////

    // window end is a single-cycle strobe
    a_tick_single : assert property (@(posedge i_clk) disable iff (i_reset)
        i_window_tick |=> !i_window_tick)
    else
    begin
        fail_count++;
        $error("window tick high for two cycles in a row");
    end

    // fifo is empty coming out of reset
    a_valid_after_reset : assert property (@(posedge i_clk)
        i_reset |=> !i_pipe_valid)
    else
    begin
        fail_count++;
        $error("pipe valid high in the cycle after reset");
    end

    // overflow latches until the next reset
    a_overflow_sticky : assert property (@(posedge i_clk) disable iff (i_reset)
        i_overflow |=> i_overflow)
    else
    begin
        fail_count++;
        $error("overflow flag fell without a reset");
    end

    ////////////////////////////////////////////////////////////////////////////
    // counter -> fifo records
    ////////////////////////////////////////////////////////////////////////////

    // channel field in [31:24] must name a real channel
    a_chan_range : assert property (@(posedge i_clk) disable iff (i_reset)
        i_rec_valid |-> (i_rec_data[31:24] < 8'(NUM_CH)))
    else
    begin
        fail_count++;
        $error("record written with a channel number out of range");
    end

endmodule

`default_nettype wire

// ==== test/spike_rate_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module spike_rate_tb;

    localparam int NUM_CH     = 4;
    localparam int FIFO_DEPTH = 16;

    // run length, counted in windows per phase
    localparam int RESET_CYCLES  = 4;
    localparam int FIRST_WINDOWS = 6;
    localparam int LONG_WINDOWS  = 4;
    localparam int MASK_WINDOWS  = 3;
    localparam int SHORT_WINDOWS = 3;
    localparam int STALL_WINDOWS = FIFO_DEPTH / NUM_CH + 2;
    localparam int HOLD_WINDOWS  = 2;
    localparam int TEST_CYCLES   = RESET_CYCLES
        + 10 * (FIRST_WINDOWS + 3)
        + 20 * (LONG_WINDOWS + MASK_WINDOWS + 1)
        + (NUM_CH + 1) * (SHORT_WINDOWS + STALL_WINDOWS + HOLD_WINDOWS);
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 2 + 100;
    localparam int TICK_LIMIT      = 64;
    localparam int DRAIN_LIMIT     = 100;
    localparam int MUTED_CH        = 2;

    logic                       ep50trig     = 1'b0;
    logic                       reset_global = 1'b1;
    logic [NUM_CH-1:0]          i_spike      = '0;
    spike_rate_pkg::host_word_t i_trig       = '0;
    spike_rate_pkg::host_word_t i_wire_hi    = '0;
    spike_rate_pkg::host_word_t i_wire_lo    = '0;
    logic                       i_pipe_read  = 1'b0;
    logic                       o_pipe_valid;
    spike_rate_pkg::host_word_t o_pipe_data;
    logic                       o_overflow;
    logic                       o_window_tick;

    // stimulus state
    int   seed = 28314;
    logic spikes_on = 1'b0;
    logic read_on   = 1'b0;
    int   hold [NUM_CH];
    int   sent [NUM_CH];

    // tick model
    int   cyc         = 0;
    logic released    = 1'b0;
    int   last_tick   = 0;
    int   tick_count  = 0;
    int   cur_period  = 10;
    int   next_period = 10;

    // readback model
    logic                       have_low  = 1'b0;
    spike_rate_pkg::host_word_t low_word  = '0;
    int                         rec_count = 0;
    int                         sums [NUM_CH];
    int                         mask_win  = -1;

    // one counter per checking process
    int tick_errs = 0;
    int rec_errs  = 0;
    int step_errs = 0;

    spike_rate_top #(
        .NUM_CH     (NUM_CH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_spike_rate_top (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_spike       (i_spike),
        .i_trig        (i_trig),
        .i_wire_hi     (i_wire_hi),
        .i_wire_lo     (i_wire_lo),
        .i_pipe_read   (i_pipe_read),
        .o_pipe_valid  (o_pipe_valid),
        .o_pipe_data   (o_pipe_data),
        .o_overflow    (o_overflow),
        .o_window_tick (o_window_tick)
    );

    bind spike_rate_top spike_rate_asserts #(.NUM_CH(NUM_CH)) u_asserts (
        .i_clk         (ep50trig),
        .i_reset       (reset_global),
        .i_window_tick (o_window_tick),
        .i_pipe_valid  (o_pipe_valid),
        .i_overflow    (o_overflow),
        .i_rec_valid   (rec_valid),
        .i_rec_data    (rec_data)
    );

    initial
    begin
        forever #5 ep50trig = ~ep50trig;
    end

    always @(posedge ep50trig)
    begin
        cyc <= cyc + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic show_mismatch(input string name, input int got, input int exp);
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    endtask

    // value onto the wires and a one-cycle pulse on the trigger bit
    task automatic load_param(input int idx, input spike_rate_pkg::param_t value);
        @(posedge ep50trig);
        i_wire_hi <= value[31:16];
        i_wire_lo <= value[15:0];
        i_trig    <= spike_rate_pkg::host_word_t'(1 << idx);
        @(posedge ep50trig);
        i_trig    <= '0;
    endtask

    // short lengths are raised to NUM_CH, window is len + 1
    task automatic set_window(input int len);
        load_param(spike_rate_pkg::TRIG_WINDOW, spike_rate_pkg::param_t'(len));
        next_period = ((len < NUM_CH) ? NUM_CH : len) + 1;
    endtask

    task automatic wait_ticks(input int n);
        int seen;
        int waited;
        seen   = 0;
        waited = 0;
        while (seen < n)
        begin
            @(negedge ep50trig);
            waited++;
            if (o_window_tick)
            begin
                seen++;
                waited = 0;
            end
            else if (waited > TICK_LIMIT)
            begin
                step_errs++;
                $display("no window tick within %0d cycles", TICK_LIMIT);
                seen = n;
            end
        end
    endtask

    // every tick so far has delivered its NUM_CH records
    task automatic wait_drained();
        int waited;
        waited = 0;
        @(posedge ep50trig);
        while ((rec_count != tick_count * NUM_CH || have_low) && waited < DRAIN_LIMIT)
        begin
            @(posedge ep50trig);
            waited++;
        end
        if (waited >= DRAIN_LIMIT)
        begin
            step_errs++;
            $display("records not read back within %0d cycles", DRAIN_LIMIT);
        end
    endtask

    task automatic check_record(input spike_rate_pkg::record_t rec);
        int chan;
        int count;
        int win;
        chan  = int'(rec[31:24]);
        count = int'(rec[23:0]);
        win   = rec_count / NUM_CH;
        // channels 0..NUM_CH-1 in order, every window
        assert (chan == rec_count % NUM_CH)
        else
        begin
            rec_errs++;
            show_mismatch("record channel", chan, rec_count % NUM_CH);
        end
        if (chan < NUM_CH)
            sums[chan] += count;
        // muted channel reads zero from the first full masked window
        if (mask_win >= 0 && win >= mask_win && chan == MUTED_CH)
        begin
            assert (count == 0)
            else
            begin
                rec_errs++;
                show_mismatch("muted record count", count, 0);
            end
        end
        rec_count++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // spike sources
    ////////////////////////////////////////////////////////////////////////////

    // 2 cycles high, 2 or more low, random gap
    always @(posedge ep50trig)
    begin : drive_spikes
        int gap;
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            if (reset_global)
            begin
                i_spike[ch] <= 1'b0;
                hold[ch]    <= 0;
            end
            else if (hold[ch] > 0)
            begin
                hold[ch] <= hold[ch] - 1;
            end
            else if (i_spike[ch])
            begin
                gap = int'($unsigned($random(seed)) % 32'd6);
                i_spike[ch] <= 1'b0;
                hold[ch]    <= 1 + gap;
            end
            else if (spikes_on)
            begin
                i_spike[ch] <= 1'b1;
                hold[ch]    <= 1;
                sent[ch]    = sent[ch] + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // host pipe reader and tick monitor
    ////////////////////////////////////////////////////////////////////////////

    // strobe held while reading, ignored by the DUT when nothing is valid
    always @(posedge ep50trig)
    begin
        if (reset_global)
            i_pipe_read <= 1'b0;
        else
            i_pipe_read <= read_on;
    end

    // word shown now is the one taken at the next edge
    always @(negedge ep50trig)
    begin
        if (!reset_global && i_pipe_read && o_pipe_valid)
        begin
            if (!have_low)
            begin
                low_word = o_pipe_data;
                have_low = 1'b1;
            end
            else
            begin
                have_low = 1'b0;
                check_record({o_pipe_data, low_word});
            end
        end
    end

    // first window counts from the release cycle
    always @(negedge ep50trig)
    begin
        if (!reset_global)
        begin
            if (!released)
            begin
                released  = 1'b1;
                last_tick = cyc - 1;
            end
            if (o_window_tick)
            begin
                assert (cyc - last_tick == cur_period)
                else
                begin
                    tick_errs++;
                    show_mismatch("o_window_tick spacing", cyc - last_tick, cur_period);
                end
                last_tick  = cyc;
                tick_count++;
                // new length takes over one window after the load
                cur_period = next_period;
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge ep50trig);
        $display("watchdog expired after %0d cycles, test did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin : run_tests
        int total;
        int asserted;
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            sent[ch] = 0;
            sums[ch] = 0;
        end
        repeat (RESET_CYCLES) @(posedge ep50trig);
        reset_global <= 1'b0;

        // outputs quiet out of reset
        @(negedge ep50trig);
        assert (o_pipe_valid == 1'b0)
        else
        begin
            step_errs++;
            show_mismatch("o_pipe_valid", int'(o_pipe_valid), 0);
        end
        assert (o_overflow == 1'b0)
        else
        begin
            step_errs++;
            show_mismatch("o_overflow", int'(o_overflow), 0);
        end

        // default 10-cycle windows
        spikes_on = 1'b1;
        read_on   = 1'b1;
        wait_ticks(FIRST_WINDOWS);

        // quiet inputs, two full windows, then totals must match
        spikes_on = 1'b0;
        wait_ticks(2);
        wait_drained();
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            assert (sums[ch] == sent[ch])
            else
            begin
                step_errs++;
                show_mismatch($sformatf("count sum ch%0d", ch), sums[ch], sent[ch]);
            end
        end

        // 20-cycle windows
        set_window(19);
        spikes_on = 1'b1;
        wait_ticks(LONG_WINDOWS);

        // mute one channel, spikes keep coming on it
        load_param(spike_rate_pkg::TRIG_ENABLE,
                   spike_rate_pkg::param_t'(((1 << NUM_CH) - 1) & ~(1 << MUTED_CH)));
        mask_win = tick_count;
        wait_ticks(MASK_WINDOWS);

        // length 1 clamps to NUM_CH
        set_window(1);
        wait_ticks(SHORT_WINDOWS);
        assert (o_overflow == 1'b0)
        else
        begin
            step_errs++;
            show_mismatch("o_overflow", int'(o_overflow), 0);
        end

        // host stops reading, fifo fills and drops
        read_on = 1'b0;
        wait_ticks(STALL_WINDOWS);
        assert (o_overflow == 1'b1)
        else
        begin
            step_errs++;
            show_mismatch("o_overflow", int'(o_overflow), 1);
        end
        wait_ticks(HOLD_WINDOWS);
        assert (o_overflow == 1'b1)
        else
        begin
            step_errs++;
            show_mismatch("o_overflow", int'(o_overflow), 1);
        end

        repeat (2) @(posedge ep50trig);
        total    = tick_errs + rec_errs + step_errs;
        asserted = u_spike_rate_top.u_asserts.fail_count;
        $display("errors: ticks %0d, records %0d, steps %0d, assertions %0d",
                 tick_errs, rec_errs, step_errs, asserted);
        if (total == 0 && asserted == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
